/* ita_pkg.sv */
/* Shared sizes and types of the tiled linear engine.
   M and N are powers of two. Matrix sizes run from 1 to 255. */
package ita_pkg;

  localparam int unsigned M         = 4;  // rows per tile
  localparam int unsigned N         = 4;  // lanes, inner chunk and tile columns
  localparam int unsigned WI        = 8;  // input and weight elements
  localparam int unsigned WO        = 26; // accumulator, holds the largest inner sum
  localparam int unsigned WB        = 24; // bias value
  localparam int unsigned FifoDepth = 4;  // default rows in flight

  typedef logic [7:0] counter_t;

  typedef enum logic {
    Idle,
    MatMul
  } step_e;

  typedef struct packed {
    logic              start;       // one-cycle pulse, taken in Idle only
    counter_t          seq_length;
    counter_t          embed_size;
    counter_t          proj_space;
    logic [7:0]        eps_mult;    // unsigned multiplier
    logic [4:0]        right_shift;
    logic signed [7:0] add;
  } ctrl_t;

  typedef logic [N-1:0][WI-1:0] inp_t;

  // lane j holds the weights of output column j, index k is the inner position
  typedef logic [N-1:0][N-1:0][WI-1:0] weight_t;

  typedef logic [N-1:0][WB-1:0] bias_t;

  typedef logic [N-1:0][WO-1:0] acc_t;

  typedef logic [N-1:0][WI-1:0] oup_t;

  // travels with each result row
  typedef struct packed {
    logic     valid;
    counter_t row;        // global row index
    counter_t col_base;   // global index of lane 0
    logic     last_inner;
  } pos_t;

endpackage

/* ita_controller.sv */
/* Tile sequencer. ctrl_i must stay stable while busy_o is high and the
   producer must follow the beat order tile_y, tile_x, inner, row. */
module ita_controller
  import ita_pkg::*;
#(
  parameter int unsigned FifoDepth = ita_pkg::FifoDepth
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  ctrl_t    ctrl_i,
  input  logic     inp_valid_i,
  input  logic     weight_valid_i,
  input  logic     bias_valid_i,
  input  logic     oup_pop_i,
  output logic     inp_ready_o,
  output logic     weight_ready_o,
  output logic     bias_ready_o,
  output logic     calc_en_o,
  output logic     first_inner_o,
  output counter_t row_o,
  output pos_t     pos_o,
  output logic     busy_o
);

  localparam int unsigned OngW = $clog2(FifoDepth + 1);

  step_e           step_d, step_q;
  counter_t        row_d, row_q;
  counter_t        inner_d, inner_q;
  counter_t        tile_x_d, tile_x_q;
  counter_t        tile_y_d, tile_y_q;
  logic [OngW-1:0] ongoing_d, ongoing_q;
  pos_t            pos_d, pos_q;

  counter_t tiles_s, tiles_e, tiles_p;
  logic     stall, last_row, last_inner, row_done;

  function automatic counter_t ceil_div(counter_t n, int unsigned d);
    logic [8:0] sum;
    sum = {1'b0, n} + 9'(d - 1); // 9 bits, 255 plus d-1 must not wrap
    return counter_t'(sum / 9'(d));
  endfunction

  assign tiles_s = ceil_div(ctrl_i.seq_length, M);
  assign tiles_e = ceil_div(ctrl_i.embed_size, N);
  assign tiles_p = ceil_div(ctrl_i.proj_space, N);

  assign stall         = (ongoing_q >= OngW'(FifoDepth)); // output FIFO could fill up
  assign last_row      = (row_q == counter_t'(M - 1));
  assign last_inner    = (inner_q == tiles_e - 8'd1);
  assign row_done      = calc_en_o && last_inner;
  assign first_inner_o = (inner_q == '0);
  assign row_o         = row_q;
  assign pos_o         = pos_q;
  assign busy_o        = (step_q != Idle) || (ongoing_q != '0);

  always_comb begin
    step_d         = step_q;
    row_d          = row_q;
    inner_d        = inner_q;
    tile_x_d       = tile_x_q;
    tile_y_d       = tile_y_q;
    ongoing_d      = ongoing_q;
    inp_ready_o    = 1'b0;
    weight_ready_o = 1'b0;
    bias_ready_o   = 1'b0;
    calc_en_o      = 1'b0;

    // cross-valid handshake
    if (step_q == MatMul && !stall) begin
      inp_ready_o    = weight_valid_i;
      weight_ready_o = inp_valid_i;
      bias_ready_o   = weight_valid_i;
      calc_en_o      = inp_valid_i && weight_valid_i && bias_valid_i;
    end

    case (step_q)
      Idle: begin
        row_d    = '0;
        inner_d  = '0;
        tile_x_d = '0;
        tile_y_d = '0;
        if (ctrl_i.start) begin
          step_d = MatMul;
        end
      end
      MatMul: begin
        if (calc_en_o) begin
          row_d = row_q + 8'd1;
          if (last_row) begin // end of inner chunk
            row_d   = '0;
            inner_d = inner_q + 8'd1;
            if (last_inner) begin // end of tile
              inner_d  = '0;
              tile_x_d = tile_x_q + 8'd1;
              if (tile_x_q == tiles_p - 8'd1) begin
                tile_x_d = '0;
                tile_y_d = tile_y_q + 8'd1;
                if (tile_y_q == tiles_s - 8'd1) begin // last beat of the job
                  tile_y_d = '0;
                  step_d   = Idle;
                end
              end
            end
          end
        end
      end
    endcase

    // rows taken but not yet popped
    if (row_done && !oup_pop_i) begin
      ongoing_d = ongoing_q + 1'b1;
    end else if (oup_pop_i && !row_done) begin
      ongoing_d = ongoing_q - 1'b1;
    end

    pos_d.valid      = calc_en_o;
    pos_d.row        = counter_t'(tile_y_q * M) + row_q;
    pos_d.col_base   = counter_t'(tile_x_q * N);
    pos_d.last_inner = last_inner;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q    <= Idle;
      row_q     <= '0;
      inner_q   <= '0;
      tile_x_q  <= '0;
      tile_y_q  <= '0;
      ongoing_q <= '0;
      pos_q     <= '0;
    end else begin
      step_q    <= step_d;
      row_q     <= row_d;
      inner_q   <= inner_d;
      tile_x_q  <= tile_x_d;
      tile_y_q  <= tile_y_d;
      ongoing_q <= ongoing_d;
      pos_q     <= pos_d; // aligned with the array result
    end
  end

endmodule

/* ita_dotp_array.sv */
/* N by N signed int8 multiply array with one accumulator per tile row.
   acc_o shows the updated entry one cycle after the beat. */
module ita_dotp_array
  import ita_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     calc_en_i,
  input  logic     first_inner_i,
  input  counter_t row_i,
  input  inp_t     inp_i,
  input  weight_t  weight_i,
  output acc_t     acc_o
);

  localparam int unsigned RowW = (M > 1) ? $clog2(M) : 1;
  localparam int unsigned SumW = 2 * WI + $clog2(N); // N products of two int8

  acc_t                   buf_q [M];
  acc_t                   sum;
  logic signed [SumW-1:0] dot [N];
  logic [RowW-1:0]        wr_row, rd_row_q;

  assign wr_row = row_i[RowW-1:0];

  always_comb begin
    for (int j = 0; j < N; j++) begin
      dot[j] = '0;
      for (int k = 0; k < N; k++) begin
        dot[j] = dot[j] + SumW'($signed(inp_i[k]) * $signed(weight_i[j][k]));
      end
      sum[j] = WO'(dot[j]); // sign extended
    end
  end

  always_ff @(posedge clk_i) begin
    if (calc_en_i) begin
      if (first_inner_i) begin
        buf_q[wr_row] <= sum; // overwrite on first chunk
      end else begin
        for (int j = 0; j < N; j++) begin
          buf_q[wr_row][j] <= buf_q[wr_row][j] + sum[j];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_row_q <= '0;
    end else if (calc_en_i) begin
      rd_row_q <= wr_row;
    end
  end

  assign acc_o = buf_q[rd_row_q];

endmodule

/* ita_requant_oup.sv */
/* Bias add, requant to int8, padding mask and output FIFO.
   Round half up is applied only for a nonzero shift. No overflow check,
   the controller keeps at most FifoDepth rows in flight. */
module ita_requant_oup
  import ita_pkg::*;
#(
  parameter int unsigned FifoDepth = ita_pkg::FifoDepth
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  ctrl_t ctrl_i,
  input  pos_t  pos_i,
  input  acc_t  acc_i,
  input  bias_t bias_i,
  output oup_t  oup_o,
  output logic  oup_valid_o,
  input  logic  oup_ready_i,
  output logic  oup_pop_o
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned SumW = ((WO > WB) ? WO : WB) + 1;
  localparam int unsigned MulW = SumW + 9 + 1; // headroom for the rounding add

  bias_t           bias_q;
  oup_t            res;
  oup_t            mem_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push, pop;

  logic signed [SumW-1:0] biased;
  logic signed [MulW-1:0] scaled, rounded, summed;

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    bias_q <= bias_i; // bias of the beat before, lines up with acc_i
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      biased  = SumW'($signed(acc_i[i])) + SumW'($signed(bias_q[i]));
      scaled  = MulW'(biased) * $signed({1'b0, ctrl_i.eps_mult});
      rounded = scaled;
      if (ctrl_i.right_shift != '0) begin
        rounded = scaled + (MulW'(1) <<< (ctrl_i.right_shift - 5'd1));
      end
      summed = (rounded >>> ctrl_i.right_shift) + MulW'($signed(ctrl_i.add));
      if (summed > 127) begin
        res[i] = 8'h7f;
      end else if (summed < -128) begin
        res[i] = 8'h80;
      end else begin
        res[i] = summed[WI-1:0];
      end
      // zero the padding outside the matrix
      if ((pos_i.row >= ctrl_i.seq_length) ||
          (({1'b0, pos_i.col_base} + 9'(i)) >= {1'b0, ctrl_i.proj_space})) begin
        res[i] = '0;
      end
    end
  end

  assign push        = pos_i.valid && pos_i.last_inner;
  assign oup_valid_o = (cnt_q != '0);
  assign pop         = oup_valid_o && oup_ready_i;
  assign oup_pop_o   = pop;
  assign oup_o       = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= res;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

/* ita_linear_top.sv */
/* Linear layer engine, MatMul only.
   ctrl_i is held while busy_o is high. */
module ita_linear_top
  import ita_pkg::*;
#(
  parameter int unsigned FifoDepth = ita_pkg::FifoDepth
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  ctrl_t   ctrl_i,
  input  inp_t    inp_i,
  input  logic    inp_valid_i,
  output logic    inp_ready_o,
  input  weight_t weight_i,
  input  logic    weight_valid_i,
  output logic    weight_ready_o,
  input  bias_t   bias_i,
  input  logic    bias_valid_i,
  output logic    bias_ready_o,
  output oup_t    oup_o,
  output logic    oup_valid_o,
  input  logic    oup_ready_i,
  output logic    busy_o
);

  logic     calc_en, first_inner, oup_pop;
  counter_t row;
  pos_t     pos;
  acc_t     acc;

  ita_controller #(
    .FifoDepth (FifoDepth)
  ) i_controller (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_i         (ctrl_i),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .oup_pop_i      (oup_pop),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .calc_en_o      (calc_en),
    .first_inner_o  (first_inner),
    .row_o          (row),
    .pos_o          (pos),
    .busy_o         (busy_o)
  );

  ita_dotp_array i_dotp_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .calc_en_i     (calc_en),
    .first_inner_i (first_inner),
    .row_i         (row),
    .inp_i         (inp_i),
    .weight_i      (weight_i),
    .acc_o         (acc)
  );

  ita_requant_oup #(
    .FifoDepth (FifoDepth)
  ) i_requant_oup (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctrl_i      (ctrl_i),
    .pos_i       (pos),
    .acc_i       (acc),
    .bias_i      (bias_i),
    .oup_o       (oup_o),
    .oup_valid_o (oup_valid_o),
    .oup_ready_i (oup_ready_i),
    .oup_pop_o   (oup_pop)
  );

endmodule

/* tb_ita_model.svh */
/* Reference model, included inside the testbench module.
   Reads x_mem, w_mem and b_mem and queues the expected output rows in exp_q. */
`ifndef TB_ITA_MODEL_SVH
`define TB_ITA_MODEL_SVH

  // round half up on a nonzero shift, then saturate
  function automatic logic [WI-1:0] requant(longint sum, ctrl_t cfg);
    longint         v;
    int             sh;
    logic [WI-1:0]  res;
    sh = int'(cfg.right_shift);
    v  = sum * longint'(cfg.eps_mult);
    if (sh > 0) begin
      v = (v + (longint'(1) <<< (sh - 1))) >>> sh;
    end
    v = v + longint'($signed(cfg.add));
    if (v > 127) begin
      res = 8'h7f;
    end else if (v < -128) begin
      res = 8'h80;
    end else begin
      res = WI'(v);
    end
    return res;
  endfunction

  // rows in the order tile_y, tile_x, row
  task automatic build_expected(input ctrl_t cfg);
    int     rows, cols, row, col;
    longint sum;
    oup_t   beat;
    rows = ((cfg.seq_length + M - 1) / M) * M;
    cols = ((cfg.proj_space + N - 1) / N) * N;
    for (int ty = 0; ty < rows; ty += M) begin
      for (int tx = 0; tx < cols; tx += N) begin
        for (int r = 0; r < M; r++) begin
          row = ty + r;
          for (int j = 0; j < N; j++) begin
            col     = tx + j;
            beat[j] = '0; // padding stays zero
            if (row < cfg.seq_length && col < cfg.proj_space) begin
              sum = longint'(b_mem[col]);
              for (int k = 0; k < cfg.embed_size; k++) begin
                sum += longint'(x_mem[row][k]) * longint'(w_mem[k][col]);
              end
              beat[j] = requant(sum, cfg);
            end
          end
          exp_q.push_back(beat);
        end
      end
    end
  endtask

`endif

/* tb_ita_linear.sv */
/* Testbench of the linear engine with random jobs from a fixed seed.
   Matrix sizes up to 16. Output rows are checked in order against the included model. */
module tb_ita_linear
  import ita_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MaxDim  = 16;
  localparam int unsigned NumJobs = 6;

  logic    clk_i, rst_ni;
  ctrl_t   ctrl_i;
  inp_t    inp_i;
  weight_t weight_i;
  bias_t   bias_i;
  oup_t    oup_o;
  logic    inp_valid_i, weight_valid_i, bias_valid_i, oup_ready_i;
  logic    inp_ready_o, weight_ready_o, bias_ready_o, oup_valid_o, busy_o;

  // exact, ragged, long inner, output hold, saturation, back to back
  int job_s    [NumJobs] = '{8, 7, 4, 8, 4, 5};
  int job_e    [NumJobs] = '{8, 4, 16, 12, 4, 7};
  int job_p    [NumJobs] = '{8, 6, 4, 8, 8, 3};
  int job_sh   [NumJobs] = '{16, 14, 17, 16, 2, 15};
  bit job_big  [NumJobs] = '{0, 0, 0, 0, 1, 0};
  bit job_hold [NumJobs] = '{0, 0, 0, 1, 0, 0};

  logic signed [WI-1:0] x_mem [MaxDim][MaxDim]; // row, inner
  logic signed [WI-1:0] w_mem [MaxDim][MaxDim]; // inner, column
  logic signed [WB-1:0] b_mem [MaxDim];
  oup_t                 exp_q [$];

  logic [31:0] rng_state = 32'd80764;
  int          errors = 0;
  int          checks = 0;
  int          b_ty, b_tx, b_in, b_r, beats_left;
  int          n_te, n_tp;
  int          in_flight, stall_cycles;

  `include "tb_ita_model.svh"

  ita_linear_top #(
    .FifoDepth (FifoDepth)
  ) UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_i         (ctrl_i),
    .inp_i          (inp_i),
    .inp_valid_i    (inp_valid_i),
    .inp_ready_o    (inp_ready_o),
    .weight_i       (weight_i),
    .weight_valid_i (weight_valid_i),
    .weight_ready_o (weight_ready_o),
    .bias_i         (bias_i),
    .bias_valid_i   (bias_valid_i),
    .bias_ready_o   (bias_ready_o),
    .oup_o          (oup_o),
    .oup_valid_o    (oup_valid_o),
    .oup_ready_i    (oup_ready_i),
    .busy_o         (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int job_beats(int s, int e, int p);
    return ((s + M - 1) / M) * ((p + N - 1) / N) * ((e + N - 1) / N) * M;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic setup_job(input int j, output ctrl_t cfg);
    cfg             = '0;
    cfg.start       = 1'b1;
    cfg.seq_length  = counter_t'(job_s[j]);
    cfg.embed_size  = counter_t'(job_e[j]);
    cfg.proj_space  = counter_t'(job_p[j]);
    cfg.eps_mult    = 8'(xorshift32()) | 8'h40;
    cfg.right_shift = 5'(job_sh[j]);
    cfg.add         = 8'(xorshift32());
    for (int r = 0; r < MaxDim; r++) begin
      for (int k = 0; k < MaxDim; k++) begin
        x_mem[r][k] = (k < job_e[j]) ? WI'(xorshift32()) : '0; // zero past embed_size
        w_mem[r][k] = WI'(xorshift32());
      end
      if (job_big[j]) begin
        b_mem[r] = WB'(xorshift32());
      end else begin
        b_mem[r] = WB'($signed(13'(xorshift32())));
      end
    end
    n_te         = (job_e[j] + N - 1) / N;
    n_tp         = (job_p[j] + N - 1) / N;
    beats_left   = job_beats(job_s[j], job_e[j], job_p[j]);
    b_ty         = 0;
    b_tx         = 0;
    b_in         = 0;
    b_r          = 0;
    in_flight    = 0;
    stall_cycles = 0;
    build_expected(cfg);
  endtask

  function automatic void advance_beat();
    b_r++;
    if (b_r == M) begin
      b_r = 0;
      b_in++;
      if (b_in == n_te) begin
        b_in = 0;
        b_tx++;
        if (b_tx == n_tp) begin
          b_tx = 0;
          b_ty++;
        end
      end
    end
    beats_left--;
  endfunction

  function automatic inp_t inp_chunk();
    inp_t v;
    for (int k = 0; k < N; k++) begin
      v[k] = x_mem[b_ty * M + b_r][b_in * N + k];
    end
    return v;
  endfunction

  function automatic weight_t weight_block();
    weight_t v;
    for (int j = 0; j < N; j++) begin
      for (int k = 0; k < N; k++) begin
        v[j][k] = w_mem[b_in * N + k][b_tx * N + j];
      end
    end
    return v;
  endfunction

  function automatic bias_t bias_slice();
    bias_t v;
    for (int j = 0; j < N; j++) begin
      v[j] = b_mem[b_tx * N + j];
    end
    return v;
  endfunction

  initial begin
    ctrl_t cfg;
    oup_t  want;
    logic  taken, popped;
    int    cyc;
    ctrl_i         = '0;
    inp_i          = '0;
    weight_i       = '0;
    bias_i         = '0;
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;
    oup_ready_i    = 1'b0;
    rst_ni         = 1'b0;
    cyc            = 0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("outputs after reset",
                {inp_ready_o, weight_ready_o, bias_ready_o, oup_valid_o, busy_o}, '0);

    for (int j = 0; j < NumJobs; j++) begin
      setup_job(j, cfg);
      @(posedge clk_i);
      ctrl_i <= cfg;
      @(posedge clk_i);
      ctrl_i.start <= 1'b0;
      @(negedge clk_i);
      check_value("busy_o after start", busy_o, 1);
      while (beats_left > 0 || exp_q.size() > 0) begin
        taken  = inp_valid_i && inp_ready_o && weight_valid_i && weight_ready_o &&
                 bias_valid_i && bias_ready_o;
        popped = oup_valid_o && oup_ready_i;
        check_value("busy_o during job", busy_o, 1);
        if (in_flight >= FifoDepth) begin // every slot of the FIFO is spoken for
          stall_cycles++;
          check_value("ready outputs while stalled",
                      {inp_ready_o, weight_ready_o, bias_ready_o}, '0);
        end
        if (popped) begin
          if (exp_q.size() == 0) begin
            errors++;
            $display("error at %0t ns: output beat beyond the end of the job", $time);
          end else begin
            want = exp_q.pop_front();
            check_value("oup_o", oup_o, want);
            in_flight--;
          end
        end
        if (taken) begin
          if (b_in == n_te - 1) begin
            in_flight++;
          end
          advance_beat();
        end

        @(posedge clk_i);
        cyc++;
        if (beats_left > 0) begin
          inp_i          <= inp_chunk();
          weight_i       <= weight_block();
          bias_i         <= bias_slice();
          inp_valid_i    <= (xorshift32() % 8) != 0;
          weight_valid_i <= (xorshift32() % 8) != 0;
          bias_valid_i   <= (xorshift32() % 8) != 0;
        end else begin
          inp_valid_i    <= 1'b0;
          weight_valid_i <= 1'b0;
          bias_valid_i   <= 1'b0;
        end
        if (job_hold[j] && (cyc % 32) < 24) begin
          oup_ready_i <= 1'b0; // long back-pressure
        end else begin
          oup_ready_i <= (xorshift32() % 4) != 0;
        end
        @(negedge clk_i);
      end
      check_value("busy_o after job", busy_o, 0);
      check_value("oup_valid_o after job", oup_valid_o, 0);
      if (job_hold[j]) begin
        check_value("stall seen during output hold", stall_cycles > 0, 1);
      end
    end

    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog sized from the beats of all jobs
  initial begin
    int total;
    total = 0;
    for (int j = 0; j < NumJobs; j++) begin
      total += job_beats(job_s[j], job_e[j], job_p[j]);
    end
    repeat (total * 20) @(posedge clk_i);
    $display("timeout: jobs did not finish within %0d cycles", total * 20);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
ita_pkg.sv
ita_controller.sv
ita_dotp_array.sv
ita_requant_oup.sv
ita_linear_top.sv
tb_ita_linear.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then scan the log for the fail line
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_ita_linear \
  -f tb.f -o tb_sim && ./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
exit 0
